// ==== list.f ====
common/monitorPkg.sv
common/checkIf.sv
rules/objectDictionary.sv
rules/responseRules.sv
hdl/frameCapture.sv
hdl/checkTally.sv
hdl/busActivityMonitor.sv
tests/clockGen.sv
tests/monitorTb.sv

// ==== Bender.yml ====
package:
  name: bus_activity_monitor

sources:
  - files:
      - common/monitorPkg.sv
      - common/checkIf.sv
      - rules/objectDictionary.sv
      - rules/responseRules.sv
      - hdl/frameCapture.sv
      - hdl/checkTally.sv
      - hdl/busActivityMonitor.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/monitorTb.sv

// ==== tests/monitorTb.sv ====
`timescale 1ns/100ps

module monitorTb;
   import monitorPkg::*;

   localparam int WaitLimit = 20;

   logic                  clk;
   logic                  rst;
   logic [FrameWidth-1:0] uplinkFrame;
   logic [FrameWidth-1:0] downlinkFrame;
   logic                  reqMsg;
   logic                  respMsg;
   logic                  testRx;
   logic                  testTx;
   logic                  oscTrim;
   logic [7:0]            busId;
   logic                  verdictValid;
   logic                  verdictPass;
   logic [1:0]            verdictClass;
   logic [15:0]           passCount;
   logic [15:0]           failCount;

   int mismatchCount = 0;
   int timeoutCount  = 0;
   int expPasses     = 0;
   int expFails      = 0;

   clockGen clockInst (.clk(clk), .rst(rst));

   busActivityMonitor #(.CountWidth(16)) DUT
   (
      .clk           (clk),
      .rst           (rst),
      .uplinkFrame   (uplinkFrame),
      .downlinkFrame (downlinkFrame),
      .reqMsg        (reqMsg),
      .respMsg       (respMsg),
      .testRx        (testRx),
      .testTx        (testTx),
      .oscTrim       (oscTrim),
      .busId         (busId),
      .verdictValid  (verdictValid),
      .verdictPass   (verdictPass),
      .verdictClass  (verdictClass),
      .passCount     (passCount),
      .failCount     (failCount)
   );

   task automatic checkValue(input string testName, input logic [FrameWidth-1:0] expected,
                             input logic [FrameWidth-1:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
         mismatchCount++;
      end
   endtask

   function automatic logic [FrameWidth-1:0] makeSdo(input logic [10:0] cobId,
      input logic [7:0] command, input logic [15:0] index, input logic [7:0] subIndex,
      input logic [31:0] value);
      canFrame f;
      f.sdo.cobId    = cobId;
      f.sdo.command  = command;
      f.sdo.index    = index;
      f.sdo.subIndex = subIndex;
      f.sdo.value    = value;
      return f.raw;
   endfunction

   // random frame that is neither a read nor a write request
   function automatic logic [FrameWidth-1:0] randomEcho();
      logic [95:0] bits;
      canFrame     f;
      bits          = {$urandom(), $urandom(), $urandom()};
      f.raw         = bits[FrameWidth-1:0];
      f.sdo.command = 8'h05;
      return f.raw;
   endfunction

   task automatic checkVerdict(input string testName, input logic expPass,
                               input logic [1:0] expClass);
      if (expPass)
         expPasses++;
      else
         expFails++;
      checkValue({testName, " pass"}, expPass, verdictPass);
      checkValue({testName, " class"}, expClass, verdictClass);
      checkValue({testName, " passCount"}, expPasses, passCount);
      checkValue({testName, " failCount"}, expFails, failCount);
   endtask

   task automatic sendRequest(input logic [FrameWidth-1:0] up,
                              input logic [FrameWidth-1:0] down);
      @(negedge clk);
      uplinkFrame   = up;
      downlinkFrame = down;
      reqMsg        = 1'b1;
      @(negedge clk);
      reqMsg = 1'b0;
   endtask

   task automatic sendResponse(input string testName, input logic [FrameWidth-1:0] frame,
                               input logic expPass, input logic [1:0] expClass);
      int cycles;
      @(negedge clk);
      uplinkFrame = frame;
      respMsg     = 1'b1;
      @(negedge clk);
      respMsg = 1'b0;
      cycles  = 1;
      while (!verdictValid && cycles < WaitLimit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!verdictValid)
      begin
         $display("%s: no verdict within %0d cycles of the response", testName, WaitLimit);
         timeoutCount++;
      end
      else
      begin
         checkValue({testName, " latency"}, 3, cycles);
         checkVerdict(testName, expPass, expClass);
      end
   endtask

   task automatic resetTest();
      int cyc;
      checkValue("reset passCount", 0, passCount);
      checkValue("reset failCount", 0, failCount);
      cyc = 0;
      while (cyc < 10)
      begin
         @(negedge clk);
         checkValue("reset idle verdictValid", 0, verdictValid);
         cyc++;
      end
   endtask

   task automatic sdoReadTest();
      sendRequest(makeSdo(11'h601, SdoReadCmd, 16'h1018, 8'h00, 32'h0), '0);
      sendResponse("read 1018 good", makeSdo(11'h581, SdoReadAck, 16'h1018, 8'h00, 32'h1),
                   1'b1, ClassRead);
      sendResponse("read 1018 bad value",
                   makeSdo(11'h581, SdoReadAck, 16'h1018, 8'h00, 32'h2), 1'b0, ClassRead);
      sendResponse("read 1018 bad cobid",
                   makeSdo(11'h591, SdoReadAck, 16'h1018, 8'h00, 32'h1), 1'b0, ClassRead);
      sendRequest(makeSdo(11'h601, SdoReadCmd, 16'h2000, 8'h00, 32'h0), '0); // not in table
      sendResponse("read unknown abort",
                   makeSdo(11'h581, SdoAbortCmd, 16'h2000, 8'h00, 32'h0602_0000), 1'b1,
                   ClassRead);
      sendResponse("read unknown ack",
                   makeSdo(11'h581, SdoReadAck, 16'h2000, 8'h00, 32'h0), 1'b0, ClassRead);
   endtask

   task automatic sdoWriteTest();
      logic [15:0] index;
      logic [7:0]  sub;
      logic [31:0] value;
      logic [10:0] node;
      index = $urandom();
      sub   = $urandom();
      value = $urandom() | 32'h1;
      node  = 11'h600 + 11'($urandom_range(127, 1));
      sendRequest(makeSdo(node, SdoWriteCmd, index, sub, value), '0);
      sendResponse("write ack", makeSdo(node - 11'h080, SdoWriteAck, index, sub, 32'h0),
                   1'b1, ClassWrite);
      sendResponse("write nonzero value",
                   makeSdo(node - 11'h080, SdoWriteAck, index, sub, value), 1'b0, ClassWrite);
   endtask

   task automatic trimTest();
      canFrame    trimReply;
      logic [7:0] id;
      id      = $urandom();
      busId   = id;
      oscTrim = 1'b1;
      sendRequest(randomEcho(), randomEcho()); // pattern overrides both frames
      trimReply.raw          = TrimPattern;
      trimReply.sdo.subIndex = id;
      sendResponse("trim busId", trimReply.raw, 1'b1, ClassTrim);
      trimReply.sdo.subIndex = id ^ 8'h5a;
      sendResponse("trim wrong byte", trimReply.raw, 1'b0, ClassTrim);
      oscTrim = 1'b0;
   endtask

   task automatic echoTest();
      logic [FrameWidth-1:0] down;
      logic [FrameWidth-1:0] req;
      logic [FrameWidth-1:0] flipped;
      int                    bitPos;
      down   = randomEcho();
      testTx = 1'b1;
      sendRequest(randomEcho(), down);
      testTx = 1'b0;
      sendResponse("echo tx", down, 1'b1, ClassEcho);
      req = randomEcho();
      sendRequest(req, down);
      sendResponse("echo default", req, 1'b1, ClassEcho);
      bitPos          = $urandom_range(FrameWidth - 1, 0);
      flipped         = req;
      flipped[bitPos] = ~flipped[bitPos];
      sendResponse("echo flipped bit", flipped, 1'b0, ClassEcho);
      req     = randomEcho();
      testRx  = 1'b1;
      testTx  = 1'b1;
      oscTrim = 1'b1;
      sendRequest(req, down); // rx test outranks trim and tx
      testRx  = 1'b0;
      testTx  = 1'b0;
      oscTrim = 1'b0;
      sendResponse("echo rx", req, 1'b1, ClassEcho);
   endtask

   // req, resp, req, resp, req, resp on consecutive cycles
   task automatic backToBackTest();
      logic [FrameWidth-1:0] reqUp [3];
      logic [FrameWidth-1:0] respUp [3];
      logic                  expPass [3];
      logic [1:0]            expClass [3];
      int                    respCycle [3];
      int                    found;
      int                    cyc;
      reqUp[0]    = randomEcho();
      respUp[0]   = reqUp[0];
      expPass[0]  = 1'b1;
      expClass[0] = ClassEcho;
      reqUp[1]    = makeSdo(11'h601, SdoReadCmd, 16'h1000, 8'h00, 32'h0);
      respUp[1]   = makeSdo(11'h581, SdoReadAck, 16'h1000, 8'h00, 32'h190); // table has 191
      expPass[1]  = 1'b0;
      expClass[1] = ClassRead;
      reqUp[2]    = makeSdo(11'h605, SdoWriteCmd, 16'h2100, 8'h01, 32'h1234);
      respUp[2]   = makeSdo(11'h585, SdoWriteAck, 16'h2100, 8'h01, 32'h0);
      expPass[2]  = 1'b1;
      expClass[2] = ClassWrite;
      found = 0;
      cyc   = 0;
      while (found < 3 && cyc < WaitLimit)
      begin
         @(negedge clk);
         if (verdictValid)
         begin
            checkValue($sformatf("back to back %0d latency", found), respCycle[found] + 3, cyc);
            checkVerdict($sformatf("back to back %0d", found), expPass[found], expClass[found]);
            found++;
         end
         reqMsg  = (cyc < 6) && (cyc % 2 == 0);
         respMsg = (cyc < 6) && (cyc % 2 == 1);
         if (cyc < 6)
         begin
            uplinkFrame = (cyc % 2 == 0) ? reqUp[cyc / 2] : respUp[cyc / 2];
            if (cyc % 2 == 1)
               respCycle[cyc / 2] = cyc;
         end
         cyc++;
      end
      if (found < 3)
      begin
         $display("back to back: only %0d of 3 verdicts arrived", found);
         timeoutCount++;
      end
   endtask

   initial
   begin
      int rstWait;
      uplinkFrame   = '0;
      downlinkFrame = '0;
      reqMsg        = 1'b0;
      respMsg       = 1'b0;
      testRx        = 1'b0;
      testTx        = 1'b0;
      oscTrim       = 1'b0;
      busId         = '0;
      void'($urandom(32'ha2f8));
      rstWait = 0;
      while (rst !== 1'b1 && rstWait < 40)
      begin
         @(negedge clk);
         rstWait++;
      end
      if (rst !== 1'b1)
      begin
         $display("reset was never released");
         timeoutCount++;
      end
      else
      begin
         resetTest();
         sdoReadTest();
         sdoWriteTest();
         trimTest();
         echoTest();
         backToBackTest();
      end
      $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
      if (mismatchCount == 0 && timeoutCount == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
(
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk; // 40 ns period
   end

   initial
   begin
      rst = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk); // release away from the active edge
      rst = 1'b1;
   end

endmodule

// ==== hdl/busActivityMonitor.sv ====
`timescale 1ns/100ps

module busActivityMonitor
#(
   parameter int CountWidth = 16
)
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic [monitorPkg::FrameWidth-1:0] uplinkFrame,
   input  logic [monitorPkg::FrameWidth-1:0] downlinkFrame,
   input  logic                              reqMsg,
   input  logic                              respMsg,
   input  logic                              testRx,
   input  logic                              testTx,
   input  logic                              oscTrim,
   input  logic [7:0]                        busId,
   output logic                              verdictValid,
   output logic                              verdictPass,
   output logic [1:0]                        verdictClass,
   output logic [CountWidth-1:0]             passCount,
   output logic [CountWidth-1:0]             failCount
);

   logic       ruleValid;
   logic       rulePass;
   logic [1:0] ruleClass;

   checkIf checkBus();

   frameCapture captureInst
   (
      .clk           (clk),
      .rst           (rst),
      .uplinkFrame   (uplinkFrame),
      .downlinkFrame (downlinkFrame),
      .reqMsg        (reqMsg),
      .respMsg       (respMsg),
      .testRx        (testRx),
      .testTx        (testTx),
      .oscTrim       (oscTrim),
      .busId         (busId),
      .check         (checkBus.capture)
   );

   responseRules rulesInst
   (
      .clk       (clk),
      .rst       (rst),
      .check     (checkBus.check),
      .ruleValid (ruleValid),
      .rulePass  (rulePass),
      .ruleClass (ruleClass)
   );

   checkTally #(.CountWidth(CountWidth)) tallyInst
   (
      .clk          (clk),
      .rst          (rst),
      .ruleValid    (ruleValid),
      .rulePass     (rulePass),
      .ruleClass    (ruleClass),
      .verdictValid (verdictValid),
      .verdictPass  (verdictPass),
      .verdictClass (verdictClass),
      .passCount    (passCount),
      .failCount    (failCount)
   );

endmodule

// ==== hdl/checkTally.sv ====
`timescale 1ns/100ps

module checkTally
#(
   parameter int CountWidth = 16
)
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  ruleValid,
   input  logic                  rulePass,
   input  logic [1:0]            ruleClass,
   output logic                  verdictValid,
   output logic                  verdictPass,
   output logic [1:0]            verdictClass,
   output logic [CountWidth-1:0] passCount,
   output logic [CountWidth-1:0] failCount
);

   logic [CountWidth:0] countSum;

   assign countSum = passCount + failCount;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         verdictValid <= 1'b0;
         passCount    <= '0;
         failCount    <= '0;
      end
      else
      begin
         verdictValid <= ruleValid;
         // counters hold at all ones
         if (ruleValid && rulePass && (passCount != '1))
            passCount <= passCount + 1'b1;
         if (ruleValid && !rulePass && (failCount != '1))
            failCount <= failCount + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ruleValid)
      begin
         verdictPass  <= rulePass;
         verdictClass <= ruleClass;
      end
   end

   tallyMonotonic : assert property (@(posedge clk) disable iff (!rst)
      countSum >= $past(countSum));

endmodule

// ==== hdl/frameCapture.sv ====
`timescale 1ns/100ps

module frameCapture
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic [monitorPkg::FrameWidth-1:0] uplinkFrame,
   input  logic [monitorPkg::FrameWidth-1:0] downlinkFrame,
   input  logic                              reqMsg,
   input  logic                              respMsg,
   input  logic                              testRx,
   input  logic                              testTx,
   input  logic                              oscTrim,
   input  logic [7:0]                        busId,
   checkIf.capture                           check
);
   import monitorPkg::*;

   logic [FrameWidth-1:0] reqSource;

   // request source by test mode, trim wins unless rx testing
   always_comb
   begin
      if (oscTrim && !testRx)
         reqSource = TrimPattern;
      else if (testRx)
         reqSource = uplinkFrame;
      else if (testTx)
         reqSource = downlinkFrame; // tx test, what we sent down
      else
         reqSource = uplinkFrame;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         check.reqFrame.raw <= '0; // zero request hits only the echo rule
         check.checkValid   <= 1'b0;
      end
      else
      begin
         check.checkValid <= respMsg;
         if (reqMsg)
            check.reqFrame.raw <= reqSource;
      end
   end

   always_ff @(posedge clk)
   begin
      if (respMsg)
      begin
         check.respFrame.raw <= uplinkFrame;
         check.busIdSnap     <= busId;
      end
   end

   // a request may not land on top of a response being judged
   reqRespExclusive : assert property (@(posedge clk) disable iff (!rst)
      !(reqMsg && respMsg));

endmodule

// ==== rules/responseRules.sv ====
`timescale 1ns/100ps

module responseRules
(
   input  logic       clk,
   input  logic       rst,
   checkIf.check      check,
   output logic       ruleValid,
   output logic       rulePass,
   output logic [1:0] ruleClass
);
   import monitorPkg::*;

   canFrame               req;
   canFrame               resp;
   canFrame               trimExpect;
   logic                  dictHit;
   logic [ValueWidth-1:0] dictValue;
   logic [1:0]            reqClass;
   logic                  cobIdOk;
   logic                  keyOk;
   logic                  passNext;

   assign req  = check.reqFrame;
   assign resp = check.respFrame;

   objectDictionary dictInst
   (
      .index    (req.sdo.index),
      .subIndex (req.sdo.subIndex),
      .hit      (dictHit),
      .value    (dictValue)
   );

   assign cobIdOk = resp.sdo.cobId == (req.sdo.cobId - SdoRespOffset);
   assign keyOk   = (resp.sdo.index == req.sdo.index) && (resp.sdo.subIndex == req.sdo.subIndex);

   always_comb
   begin
      if (req.raw == TrimPattern)
         reqClass = ClassTrim;
      else if (req.sdo.command == SdoReadCmd)
         reqClass = ClassRead;
      else if (req.sdo.command == SdoWriteCmd)
         reqClass = ClassWrite;
      else
         reqClass = ClassEcho;
   end

   // trim reply echoes the pattern with the bus id in the subindex byte
   always_comb
   begin
      trimExpect.raw          = TrimPattern;
      trimExpect.sdo.subIndex = check.busIdSnap;
   end

   always_comb
   begin
      case (reqClass)
         ClassRead:
         begin
            if (dictHit)
               passNext = cobIdOk && keyOk && (resp.sdo.command == SdoReadAck)
                          && (resp.sdo.value == dictValue);
            else
               passNext = cobIdOk && keyOk && (resp.sdo.command == SdoAbortCmd);
         end
         ClassWrite:
            passNext = cobIdOk && keyOk && (resp.sdo.command == SdoWriteAck)
                       && (resp.sdo.value == '0);
         ClassTrim:
            passNext = resp.raw == trimExpect.raw;
         default:
            passNext = resp.raw == req.raw; // plain echo
      endcase
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         ruleValid <= 1'b0;
      else
         ruleValid <= check.checkValid;
   end

   always_ff @(posedge clk)
   begin
      if (check.checkValid)
      begin
         rulePass  <= passNext;
         ruleClass <= reqClass;
      end
   end

   // each verdict carries a judged pass bit and class
   verdictKnown : assert property (@(posedge clk) disable iff (!rst)
      ruleValid |-> !$isunknown({rulePass, ruleClass}));

endmodule

// ==== rules/objectDictionary.sv ====
`timescale 1ns/100ps

module objectDictionary
(
   input  logic [monitorPkg::IndexWidth-1:0] index,
   input  logic [7:0]                        subIndex,
   output logic                              hit,
   output logic [monitorPkg::ValueWidth-1:0] value
);

   always_comb
   begin
      hit   = 1'b1;
      value = '0;
      case (index)
         16'h1000: value = 32'h0000_0191; // device type
         16'h1001: value = 32'h0000_0000; // error register
         16'h1005: value = 32'h0000_0080; // sync cob-id
         16'h1014: value = 32'h0000_0081; // emcy cob-id
         16'h1018: value = 32'h0000_0001;
         16'h1200: value = 32'h0000_0002; // sdo server parameter
         default:
         begin
            hit   = 1'b0;
            value = '0;
         end
      endcase

      // only subindex 0 is stored
      if (subIndex != 8'h00)
      begin
         hit   = 1'b0;
         value = '0;
      end
   end

endmodule

// ==== common/checkIf.sv ====
`timescale 1ns/100ps

interface checkIf;
   import monitorPkg::*;

   canFrame    reqFrame;
   canFrame    respFrame;
   logic [7:0] busIdSnap; // bus id at response time
   logic       checkValid; // one cycle, frames stable

   modport capture
   (
      output reqFrame,
      output respFrame,
      output busIdSnap,
      output checkValid
   );

   modport check
   (
      input reqFrame,
      input respFrame,
      input busIdSnap,
      input checkValid
   );

endinterface

// ==== common/monitorPkg.sv ====
package monitorPkg;

   localparam int FrameWidth = 75;
   localparam int CobIdWidth = 11;
   localparam int IndexWidth = 16;
   localparam int ValueWidth = 32;

   // SDO command bytes
   localparam logic [7:0] SdoReadCmd  = 8'h40; // expedited upload request
   localparam logic [7:0] SdoReadAck  = 8'h43;
   localparam logic [7:0] SdoWriteCmd = 8'h23; // 4-byte download request
   localparam logic [7:0] SdoWriteAck = 8'h60;
   localparam logic [7:0] SdoAbortCmd = 8'h80;

   // request 0x601 is answered on 0x581
   localparam logic [CobIdWidth-1:0] SdoRespOffset = 11'h080;

   // oscillator trim request, 555 then alternating a
   localparam logic [FrameWidth-1:0] TrimPattern = {3'h5, 72'h55aaaaaaaaaaaaaaaa};

   // rule classes
   localparam logic [1:0] ClassRead  = 2'd0;
   localparam logic [1:0] ClassWrite = 2'd1;
   localparam logic [1:0] ClassTrim  = 2'd2;
   localparam logic [1:0] ClassEcho  = 2'd3;

   typedef struct packed
   {
      logic [CobIdWidth-1:0] cobId;
      logic [7:0]            command;
      logic [IndexWidth-1:0] index;
      logic [7:0]            subIndex;
      logic [ValueWidth-1:0] value;
   } sdoFields;

   // same 75 bits seen as SDO fields or as one raw word
   typedef union packed
   {
      sdoFields              sdo;
      logic [FrameWidth-1:0] raw;
   } canFrame;

endpackage
